// File: pistorm_cfg.svh
`ifndef PISTORM_CFG_SVH
`define PISTORM_CFG_SVH

`define MC_ADDR_W 24
`define MC_DATA_W 32
`define PI_DATA_W 16

`define CTRL_W 15
// RESET and HALT held on the bus out of reset.
`define CTRL_RESET_VALUE 15'b000_0000_0000_0110

`define CTRL_BIT_REQUEST_BM 0
`define CTRL_BIT_DRIVE_RESET 1
`define CTRL_BIT_DRIVE_HALT 2
`define CTRL_BIT_DRIVE_INT2 3
`define CTRL_BIT_DRIVE_INT6 4

`define PI_REG_DATA_LO 3'd0
`define PI_REG_DATA_HI 3'd1
`define PI_REG_ADDR_LO 3'd2
`define PI_REG_ADDR_HI 3'd3
`define PI_REG_STATUS_CONTROL 3'd4

`define MC_CLK_SYNC_STAGES 10

`endif

// File: pistorm_pkg.sv
`include "pistorm_cfg.svh"

package pistorm_pkg;

    typedef logic [`MC_ADDR_W-1:0] mc_addr_t;
    typedef logic [`MC_DATA_W-1:0] mc_data_t;   // Lane 0 is bits 31:24.
    typedef logic [`PI_DATA_W-1:0] pi_word_t;
    typedef logic [2:0] fc_t;
    typedef logic [1:0] xfer_size_t;            // Bytes left minus one.
    typedef logic [1:0] port_width_t;           // 0, 1 or 3.
    typedef logic [2:0] ipl_t;

    // Bit 1 set means the FPGA drives, bit 0 selects data.
    typedef enum logic [1:0] {
        DA_IDLE,
        DA_DATA_TO_FPGA,
        DA_FPGA_TO_ADDR,
        DA_FPGA_TO_DATA
    } da_state_e;

    typedef enum logic [2:0] {
        ST_WAIT_ACTIVE,
        ST_WAIT_CYCLE_START,
        ST_WAIT_ASSERT_AS,
        ST_WAIT_OPEN_DATA,
        ST_WAIT_TERM,
        ST_WAIT_LATCH_DATA,
        ST_UPDATE_READ,
        ST_MAYBE_DONE
    } access_state_e;

endpackage

// File: mc_clk_edges.sv
`timescale 1ns/1ns
`include "pistorm_cfg.svh"

module mc_clk_edges (
    input  logic clk,
    input  logic rst_n,
    input  logic mc_clk,
    output logic clk_rising,
    output logic clk_falling,
    output logic rising_plus_1,
    output logic rising_plus_3,
    output logic falling_plus_1
);

    logic [`MC_CLK_SYNC_STAGES:0] sync;
    logic [2:0] rise_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync <= '0;
            clk_rising <= 1'b0;
            clk_falling <= 1'b0;
            rise_d <= '0;
            falling_plus_1 <= 1'b0;
        end else begin
            sync <= {sync[`MC_CLK_SYNC_STAGES-1:0], mc_clk};
            // Compare the last two stages.
            clk_rising <= sync[`MC_CLK_SYNC_STAGES-1] & ~sync[`MC_CLK_SYNC_STAGES];
            clk_falling <= ~sync[`MC_CLK_SYNC_STAGES-1] & sync[`MC_CLK_SYNC_STAGES];
            rise_d <= {rise_d[1:0], clk_rising};
            falling_plus_1 <= clk_falling;
        end
    end

    assign rising_plus_1 = rise_d[0];
    assign rising_plus_3 = rise_d[2];

endmodule

// File: pi_regs.sv
`timescale 1ns/1ns
`include "pistorm_cfg.svh"

module pi_regs import pistorm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] pi_a,
    input  pi_word_t   pi_d_in,
    input  logic       pi_wr_n,
    input  logic       pi_rd_n,
    input  logic       is_bm,
    input  logic       reset_seen,
    input  logic       halt_seen,
    input  ipl_t       ipl,
    input  logic       access_done,
    input  mc_data_t   done_data_read,
    input  logic       done_terminated_normally,
    input  mc_addr_t   cur_addr,
    output pi_word_t   pi_d_out,
    output logic       pi_d_oe,
    output logic       req_active,
    output mc_addr_t   req_addr,
    output xfer_size_t req_size,
    output logic       req_rw,
    output fc_t        req_fc,
    output mc_data_t   req_data_write,
    output logic       request_bm,
    output logic       reset_oe,
    output logic       halt_oe,
    output logic       int2_oe,
    output logic       int6_oe,
    output logic       pi_txn_in_progress
);

    logic [1:0] wr_sync;
    logic wr_strobe;
    logic [`CTRL_W-1:0] control;
    mc_data_t res_data;
    logic res_term;

    assign wr_strobe = wr_sync == 2'b10;   // Falling edge of pi_wr_n.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_sync <= 2'b11;
            control <= `CTRL_RESET_VALUE;
            req_active <= 1'b0;
            res_term <= 1'b0;
        end else begin
            wr_sync <= {wr_sync[0], pi_wr_n};
            if (wr_strobe && pi_a == `PI_REG_ADDR_HI)
                req_active <= 1'b1;
            if (wr_strobe && pi_a == `PI_REG_STATUS_CONTROL) begin
                if (pi_d_in[`CTRL_W])   // Set or clear.
                    control <= control | pi_d_in[`CTRL_W-1:0];
                else
                    control <= control & ~pi_d_in[`CTRL_W-1:0];
            end
            if (access_done) begin
                req_active <= 1'b0;
                res_term <= done_terminated_normally;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_strobe) begin
            case (pi_a)
                `PI_REG_DATA_LO: req_data_write[15:0] <= pi_d_in;
                `PI_REG_DATA_HI: req_data_write[31:16] <= pi_d_in;
                `PI_REG_ADDR_LO: req_addr[15:0] <= pi_d_in;
                `PI_REG_ADDR_HI: begin
                    req_addr[23:16] <= pi_d_in[7:0];
                    req_size <= pi_d_in[9:8];
                    req_rw <= pi_d_in[10];
                    req_fc <= pi_d_in[13:11];
                end
                default: ;
            endcase
        end
        if (access_done)
            res_data <= done_data_read;
    end

    always_comb begin
        case (pi_a)
            `PI_REG_DATA_LO: pi_d_out = res_data[15:0];
            `PI_REG_DATA_HI: pi_d_out = res_data[31:16];
            `PI_REG_ADDR_LO: pi_d_out = cur_addr[15:0];
            `PI_REG_ADDR_HI: pi_d_out = {8'd0, cur_addr[23:16]};
            `PI_REG_STATUS_CONTROL:
                pi_d_out = {8'd0, req_active, res_term, ipl, halt_seen, reset_seen, is_bm};
            default: pi_d_out = '0;
        endcase
    end

    assign pi_d_oe = !pi_rd_n && pi_wr_n;
    assign pi_txn_in_progress = req_active;

    assign request_bm = control[`CTRL_BIT_REQUEST_BM];
    assign reset_oe = control[`CTRL_BIT_DRIVE_RESET];
    assign halt_oe = control[`CTRL_BIT_DRIVE_HALT];
    assign int2_oe = control[`CTRL_BIT_DRIVE_INT2];
    assign int6_oe = control[`CTRL_BIT_DRIVE_INT6];

endmodule

// File: mc_input_sync.sv
`timescale 1ns/1ns

module mc_input_sync import pistorm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_falling,
    input  mc_data_t    da_in,
    input  logic [1:0]  dsack_n,
    input  logic        berr_n,
    input  logic        reset_n_in,
    input  logic        halt_n_in,
    input  logic [2:0]  ipl_n,
    input  logic        bg_n,
    input  logic        as_n_in,
    input  logic        request_bm,
    output mc_data_t    data_in_q,
    output port_width_t port_width,
    output logic        any_termination,
    output logic        terminated_normally,
    output logic        reset_seen,
    output logic        halt_seen,
    output ipl_t        ipl,
    output logic        is_bm
);

    logic [1:0] dsack_q;
    logic berr_q;
    logic reset_q;
    logic halt_q;
    ipl_t ipl_s0;
    ipl_t ipl_s1;
    logic bg_sync;
    logic as_sync;

    always_ff @(posedge clk) begin
        if (clk_falling)
            data_in_q <= da_in;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dsack_q <= 2'b11;
            berr_q <= 1'b1;
            reset_q <= 1'b1;
            halt_q <= 1'b1;
            ipl_s0 <= '0;
            ipl_s1 <= '0;
            ipl <= '0;
        end else if (clk_falling) begin
            dsack_q <= dsack_n;
            berr_q <= berr_n;
            reset_q <= reset_n_in;
            halt_q <= halt_n_in;
            ipl_s0 <= ~ipl_n;
            ipl_s1 <= ipl_s0;
            if (ipl_s0 == ipl_s1)   // Skew filter.
                ipl <= ipl_s0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bg_sync <= 1'b0;
            as_sync <= 1'b0;
            is_bm <= 1'b0;
        end else begin
            bg_sync <= !bg_n;
            as_sync <= !as_n_in;
            if (!request_bm)
                is_bm <= 1'b0;
            else if (bg_sync && !as_sync)   // Granted and previous cycle done.
                is_bm <= 1'b1;
        end
    end

    // DSACK encoding, Table 5-1.
    always_comb begin
        case (dsack_q)
            2'b01: port_width = 2'd1;
            2'b00: port_width = 2'd3;
            default: port_width = 2'd0;
        endcase
    end

    assign any_termination = ~&{dsack_q, berr_q, reset_q};
    assign terminated_normally = berr_q & reset_q;
    assign reset_seen = ~reset_q;
    assign halt_seen = ~halt_q;

endmodule

// File: byte_lane_router.sv
`timescale 1ns/1ns

module byte_lane_router import pistorm_pkg::*; (
    input  xfer_size_t size,
    input  logic [1:0] addr_lo,
    input  mc_data_t   data_write,
    input  logic [1:0] left_shift,
    input  mc_data_t   data_in_q,
    input  mc_data_t   data_read_q,
    output mc_data_t   lanes_write,
    output mc_data_t   data_read_next
);

    logic [7:0] w0;
    logic [7:0] w1;
    logic [7:0] w2;
    logic [7:0] w3;

    assign {w0, w1, w2, w3} = data_write;

    // Write replication, Table 5-5. Unused lanes carry a copy.
    always_comb begin
        case (size)
            2'd0: lanes_write = {w3, w3, w3, w3};
            2'd1: lanes_write = addr_lo[0] ? {w2, w2, w3, w2} : {w2, w3, w2, w3};
            2'd2: begin
                case (addr_lo)
                    2'd0: lanes_write = {w1, w2, w3, w3};
                    2'd1: lanes_write = {w1, w1, w2, w3};
                    2'd2: lanes_write = {w1, w2, w1, w2};
                    default: lanes_write = {w1, w1, w2, w1};
                endcase
            end
            default: begin
                case (addr_lo)
                    2'd0: lanes_write = {w0, w1, w2, w3};
                    2'd1: lanes_write = {w0, w0, w1, w2};
                    2'd2: lanes_write = {w0, w1, w0, w1};
                    default: lanes_write = {w0, w0, w1, w0};
                endcase
            end
        endcase
    end

    // Read realignment, Table 5-4.
    // Result byte j takes lane j + size - 3 + left_shift when in range.
    always_comb begin
        int lane;
        data_read_next = data_read_q;
        for (int j = 0; j < 4; j++) begin
            lane = j + int'(size) + int'(left_shift) - 3;
            if (j + int'(size) >= 3 && lane <= 3)
                data_read_next[31 - 8 * j -: 8] = data_in_q[31 - 8 * lane -: 8];
        end
    end

endmodule

// File: bus_cycle_fsm.sv
`timescale 1ns/1ns
`include "pistorm_cfg.svh"

module bus_cycle_fsm import pistorm_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_rising,
    input  logic        clk_falling,
    input  logic        rising_plus_1,
    input  logic        rising_plus_3,
    input  logic        falling_plus_1,
    input  logic        req_active,
    input  mc_addr_t    req_addr,
    input  xfer_size_t  req_size,
    input  logic        req_rw,
    input  fc_t         req_fc,
    input  mc_data_t    req_data_write,
    input  logic        is_bm,
    input  port_width_t port_width,
    input  logic        any_termination,
    input  logic        terminated_normally,
    input  mc_data_t    lanes_write,
    input  mc_data_t    data_read_next,
    output logic        access_done,
    output mc_data_t    done_data_read,
    output logic        done_terminated_normally,
    output mc_addr_t    cur_addr,
    output xfer_size_t  cur_size,
    output mc_data_t    cur_data_write,
    output logic [1:0]  left_shift,
    output mc_data_t    data_read_q,
    output fc_t         mc_fc,
    output logic [1:0]  mc_siz,
    output logic        mc_rw,
    output logic        as_n_out,
    output logic        ds_n_out,
    output logic        bus_oe,
    output mc_data_t    da_out,
    output mc_data_t    da_oe,
    output logic        addr_le,
    output logic        addr_oe_n,
    output logic        data_oe_n
);

    access_state_e state;
    da_state_e da_state;
    logic as_q;
    logic ds_q;
    logic rw;
    fc_t fc;
    mc_addr_t mc_addr;
    mc_data_t mc_data_write;
    xfer_size_t transferred;   // Bytes moved this cycle minus one.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ST_WAIT_ACTIVE;
            da_state <= DA_IDLE;
            as_q <= 1'b0;
            ds_q <= 1'b0;
            addr_le <= 1'b0;
            access_done <= 1'b0;
        end else begin
            access_done <= 1'b0;
            case (state)
                ST_WAIT_ACTIVE: begin
                    da_state <= DA_IDLE;
                    // Skip the cycle where the finished request is still active.
                    if (req_active && !access_done) begin
                        fc <= req_fc;
                        cur_addr <= req_addr;
                        cur_size <= req_size;
                        rw <= req_rw;
                        cur_data_write <= req_data_write;
                        data_read_q <= '0;
                        state <= ST_WAIT_CYCLE_START;
                    end
                end
                ST_WAIT_CYCLE_START: begin
                    if (clk_rising) begin   // S0.
                        da_state <= DA_IDLE;
                        mc_fc <= fc;
                        mc_addr <= cur_addr;
                        mc_rw <= rw;
                        mc_data_write <= lanes_write;
                        case (cur_size)   // Table 5-2.
                            2'd0: mc_siz <= 2'b01;
                            2'd1: mc_siz <= 2'b10;
                            2'd2: mc_siz <= 2'b11;
                            default: mc_siz <= 2'b00;
                        endcase
                        state <= ST_WAIT_ASSERT_AS;
                    end
                end
                ST_WAIT_ASSERT_AS: begin
                    if (rising_plus_1) begin
                        da_state <= DA_FPGA_TO_ADDR;
                        addr_le <= 1'b1;
                    end
                    if (rising_plus_3)
                        addr_le <= 1'b0;
                    if (clk_falling) begin   // S0 to S1.
                        as_q <= 1'b1;
                        ds_q <= rw;
                        da_state <= DA_IDLE;
                        state <= ST_WAIT_OPEN_DATA;
                    end
                end
                ST_WAIT_OPEN_DATA: begin
                    if (clk_rising) begin
                        da_state <= rw ? DA_DATA_TO_FPGA : DA_FPGA_TO_DATA;
                        state <= ST_WAIT_TERM;
                    end
                end
                ST_WAIT_TERM: begin
                    if (clk_falling)
                        ds_q <= 1'b1;   // Write data strobe.
                    if (falling_plus_1 && any_termination)
                        state <= ST_WAIT_LATCH_DATA;
                end
                ST_WAIT_LATCH_DATA: begin
                    if (clk_falling) begin
                        as_q <= 1'b0;
                        ds_q <= 1'b0;
                        left_shift <= cur_addr[1:0] & port_width;
                        transferred <= port_width - (cur_addr[1:0] & port_width);
                        state <= rw ? ST_UPDATE_READ : ST_MAYBE_DONE;
                    end
                end
                ST_UPDATE_READ: begin
                    data_read_q <= data_read_next;
                    state <= ST_MAYBE_DONE;
                end
                default: begin
                    if (!terminated_normally || cur_size <= transferred) begin
                        access_done <= 1'b1;
                        done_terminated_normally <= terminated_normally;
                        state <= ST_WAIT_ACTIVE;
                    end else begin
                        cur_addr <= cur_addr + mc_addr_t'(transferred) + 1'b1;
                        cur_size <= cur_size - transferred - 1'b1;
                        state <= ST_WAIT_CYCLE_START;
                    end
                end
            endcase
        end
    end

    assign done_data_read = data_read_q;
    assign as_n_out = ~as_q;
    assign ds_n_out = ~ds_q;
    assign bus_oe = is_bm;

    assign da_out = da_state[0] ? mc_data_write : mc_data_t'(mc_addr);
    assign da_oe = {`MC_DATA_W{is_bm && da_state[1]}};
    assign addr_oe_n = ~is_bm;
    assign data_oe_n = !(da_state == DA_DATA_TO_FPGA || da_state == DA_FPGA_TO_DATA);

endmodule

// File: pistorm.sv
`timescale 1ns/1ns

module pistorm import pistorm_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] pi_a,
    input  pi_word_t   pi_d_in,
    input  logic       pi_wr_n,
    input  logic       pi_rd_n,
    output pi_word_t   pi_d_out,
    output logic       pi_d_oe,
    output logic       pi_txn_in_progress,
    input  mc_data_t   da_in,
    output mc_data_t   da_out,
    output mc_data_t   da_oe,
    output logic       addr_le,
    output logic       addr_oe_n,
    output logic       data_oe_n,
    output fc_t        mc_fc,
    output logic [1:0] mc_siz,
    output logic       mc_rw,
    output logic       mc_as_n_out,
    output logic       mc_ds_n_out,
    output logic       mc_bus_oe,
    input  logic       mc_as_n_in,
    input  logic [1:0] mc_dsack_n,
    input  logic [2:0] mc_ipl_n,
    input  logic       mc_bg_n,
    input  logic       mc_reset_n_in,
    input  logic       mc_halt_n_in,
    input  logic       mc_berr_n,
    input  logic       mc_clk,
    output logic       br_oe,
    output logic       reset_oe,
    output logic       halt_oe,
    output logic       int2_oe,
    output logic       int6_oe
);

    logic clk_rising, clk_falling, rising_plus_1, rising_plus_3, falling_plus_1;
    logic req_active, req_rw, is_bm, reset_seen, halt_seen;
    mc_addr_t req_addr;
    xfer_size_t req_size;
    fc_t req_fc;
    mc_data_t req_data_write;
    ipl_t ipl;
    logic access_done, done_terminated_normally, any_termination, terminated_normally;
    mc_data_t done_data_read, cur_data_write, data_read_q, data_in_q;
    mc_data_t lanes_write, data_read_next;
    mc_addr_t cur_addr;
    xfer_size_t cur_size;
    logic [1:0] left_shift;
    port_width_t port_width;

    mc_clk_edges u_edges (.clk, .rst_n, .mc_clk, .clk_rising, .clk_falling,
                          .rising_plus_1, .rising_plus_3, .falling_plus_1);

    pi_regs u_pi_regs (.clk, .rst_n, .pi_a, .pi_d_in, .pi_wr_n, .pi_rd_n, .is_bm,
                       .reset_seen, .halt_seen, .ipl, .access_done, .done_data_read,
                       .done_terminated_normally, .cur_addr, .pi_d_out, .pi_d_oe,
                       .req_active, .req_addr, .req_size, .req_rw, .req_fc,
                       .req_data_write, .request_bm(br_oe), .reset_oe, .halt_oe,
                       .int2_oe, .int6_oe, .pi_txn_in_progress);

    mc_input_sync u_input_sync (.clk, .rst_n, .clk_falling, .da_in, .dsack_n(mc_dsack_n),
                                .berr_n(mc_berr_n), .reset_n_in(mc_reset_n_in),
                                .halt_n_in(mc_halt_n_in), .ipl_n(mc_ipl_n), .bg_n(mc_bg_n),
                                .as_n_in(mc_as_n_in), .request_bm(br_oe), .data_in_q,
                                .port_width, .any_termination, .terminated_normally,
                                .reset_seen, .halt_seen, .ipl, .is_bm);

    byte_lane_router u_router (.size(cur_size), .addr_lo(cur_addr[1:0]),
                               .data_write(cur_data_write), .left_shift, .data_in_q,
                               .data_read_q, .lanes_write, .data_read_next);

    bus_cycle_fsm u_fsm (.clk, .rst_n, .clk_rising, .clk_falling, .rising_plus_1,
                         .rising_plus_3, .falling_plus_1, .req_active, .req_addr, .req_size,
                         .req_rw, .req_fc, .req_data_write, .is_bm, .port_width,
                         .any_termination, .terminated_normally, .lanes_write,
                         .data_read_next, .access_done, .done_data_read,
                         .done_terminated_normally, .cur_addr, .cur_size, .cur_data_write,
                         .left_shift, .data_read_q, .mc_fc, .mc_siz, .mc_rw,
                         .as_n_out(mc_as_n_out), .ds_n_out(mc_ds_n_out), .bus_oe(mc_bus_oe),
                         .da_out, .da_oe, .addr_le, .addr_oe_n, .data_oe_n);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period.
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: tb_mc_bus_model.sv
`timescale 1ns/1ns

module tb_mc_bus_model import pistorm_pkg::*; (
    input  logic       clk,
    output logic       mc_clk,
    input  logic       as_n,
    input  logic       rw,
    input  logic [1:0] siz,
    input  mc_data_t   da_out,
    input  logic       da_oe,
    input  logic       addr_le,
    input  logic       br_oe,
    output mc_data_t   da_in,
    output logic [1:0] dsack_n,
    output logic       berr_n,
    output logic       bg_n
);

    logic [7:0] mem [256];   // Filled by the testbench.
    logic [1:0] phase_cnt;
    mc_addr_t addr_latch;

    initial begin
        mc_clk = 1'b0;
        phase_cnt = '0;
        da_in = '0;
        dsack_n = 2'b11;
        berr_n = 1'b1;
        bg_n = 1'b1;
    end

    always @(posedge clk) begin
        phase_cnt <= phase_cnt + 1'b1;
        if (phase_cnt == 2'd3)
            mc_clk <= ~mc_clk;   // 8 clk per period.
    end

    // External address latch.
    always @(posedge clk) begin
        if (addr_le && da_oe)
            addr_latch <= da_out[23:0];
    end

    always @(posedge mc_clk) begin
        bg_n <= ~br_oe;
    end

    always begin : respond
        mc_addr_t a;
        logic is_read;
        int port_bytes;
        int first;
        int count;
        int remaining;
        int k;
        @(negedge as_n);
        a = addr_latch;
        is_read = rw;
        remaining = (siz == 2'b00) ? 4 : int'(siz);
        case (a[9:8])
            2'b00: port_bytes = 4;
            2'b01: port_bytes = 2;
            default: port_bytes = 1;
        endcase
        first = int'(a[1:0]) % port_bytes;
        count = (remaining < port_bytes - first) ? remaining : port_bytes - first;
        repeat (2) @(posedge mc_clk);   // One wait state.
        if (a[9:8] == 2'b11) begin
            berr_n = 1'b0;
        end else begin
            case (port_bytes)
                4: dsack_n = 2'b00;
                2: dsack_n = 2'b01;
                default: dsack_n = 2'b10;
            endcase
            if (is_read) begin
                for (k = 0; k < count; k++)
                    da_in[31 - 8 * (first + k) -: 8] = mem[8'(a + k)];
            end
        end
        @(posedge as_n);
        if (!is_read && a[9:8] != 2'b11) begin
            for (k = 0; k < count; k++)
                mem[8'(a + k)] = da_out[31 - 8 * (first + k) -: 8];
        end
        dsack_n = 2'b11;
        berr_n = 1'b1;
        da_in = '0;
    end

endmodule

// File: tb_pistorm.sv
`timescale 1ns/1ns
`include "pistorm_cfg.svh"

module tb_pistorm import pistorm_pkg::*; ();

    localparam int NUM_ROWS = 15;
    localparam int TIMEOUT_NS = (NUM_ROWS + 4) * 4000;
    localparam fc_t FC_SUPER_DATA = 3'b101;

    logic clk, rst_n;
    logic [2:0] pi_a;
    pi_word_t pi_d_in, pi_d_out;
    logic pi_wr_n, pi_rd_n, pi_d_oe, pi_txn_in_progress;
    mc_data_t da_in, da_out, da_oe;
    logic addr_le, addr_oe_n, data_oe_n;
    fc_t mc_fc;
    logic [1:0] mc_siz, mc_dsack_n;
    logic mc_rw, mc_as_n_out, mc_ds_n_out, mc_bus_oe, mc_as_n_in;
    logic [2:0] mc_ipl_n;
    logic mc_bg_n, mc_reset_n_in, mc_halt_n_in, mc_berr_n, mc_clk;
    logic br_oe, reset_oe, halt_oe, int2_oe, int6_oe;

    logic [7:0] shadow [256];
    logic tbl_rw [NUM_ROWS];
    mc_addr_t tbl_addr [NUM_ROWS];
    xfer_size_t tbl_size [NUM_ROWS];
    mc_data_t tbl_data [NUM_ROWS];
    logic tbl_term [NUM_ROWS];
    int n_rows;
    int n_checks;
    int n_errors;
    integer seed;

    // Open-drain lines seen back at the inputs.
    assign mc_reset_n_in = ~reset_oe;
    assign mc_halt_n_in = ~halt_oe;
    assign mc_as_n_in = mc_as_n_out;

    tb_clock_gen clock_gen (.clk, .rst_n);

    tb_mc_bus_model bus_model (.clk, .mc_clk, .as_n(mc_as_n_out), .rw(mc_rw), .siz(mc_siz),
                               .da_out, .da_oe(da_oe[0]), .addr_le, .br_oe, .da_in,
                               .dsack_n(mc_dsack_n), .berr_n(mc_berr_n), .bg_n(mc_bg_n));

    pistorm dut (.*);

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error: %s got 0x%h expected 0x%h", name, got, exp);
        end
    endtask

    task automatic pi_write(input logic [2:0] a, input pi_word_t d);
        @(posedge clk);
        #1;
        pi_a = a;
        pi_d_in = d;
        pi_wr_n = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        pi_wr_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic pi_read(input logic [2:0] a, output pi_word_t d);
        @(posedge clk);
        #1;
        pi_a = a;
        pi_rd_n = 1'b0;
        @(negedge clk);
        d = pi_d_out;
        check_value("pi_d_oe", pi_d_oe, 1'b1);
        @(posedge clk);
        #1;
        pi_rd_n = 1'b1;
    endtask

    task automatic add_row(input logic rw, input mc_addr_t a, input xfer_size_t s,
                           input logic term);
        tbl_rw[n_rows] = rw;
        tbl_addr[n_rows] = a;
        tbl_size[n_rows] = s;
        tbl_data[n_rows] = $random(seed);
        tbl_term[n_rows] = term;
        n_rows++;
    endtask

    // Bits 9:8 pick the port: 0 for 32, 1 for 16, 2 for 8, 3 for BERR.
    task automatic build_table();
        add_row(1'b0, 24'h000010, 2'd3, 1'b1);
        add_row(1'b0, 24'h000115, 2'd1, 1'b1);
        add_row(1'b0, 24'h000221, 2'd3, 1'b1);
        add_row(1'b0, 24'h000132, 2'd2, 1'b1);
        add_row(1'b0, 24'h000047, 2'd0, 1'b1);
        add_row(1'b0, 24'h000013, 2'd3, 1'b1);
        add_row(1'b1, 24'h000010, 2'd3, 1'b1);
        add_row(1'b1, 24'h000014, 2'd1, 1'b1);
        add_row(1'b1, 24'h000015, 2'd1, 1'b1);
        add_row(1'b1, 24'h000021, 2'd3, 1'b1);
        add_row(1'b1, 24'h000031, 2'd2, 1'b1);
        add_row(1'b1, 24'h000147, 2'd0, 1'b1);
        add_row(1'b1, 24'h000233, 2'd2, 1'b1);
        add_row(1'b0, 24'h000320, 2'd3, 1'b0);
        add_row(1'b1, 24'h000320, 2'd1, 1'b0);
    endtask

    task automatic run_row(input int r);
        pi_word_t status;
        pi_word_t lo;
        pi_word_t hi;
        mc_data_t exp_data;
        int n;
        int k;
        pi_write(`PI_REG_DATA_LO, tbl_data[r][15:0]);
        pi_write(`PI_REG_DATA_HI, tbl_data[r][31:16]);
        pi_write(`PI_REG_ADDR_LO, tbl_addr[r][15:0]);
        pi_write(`PI_REG_ADDR_HI,
                 {2'b00, FC_SUPER_DATA, tbl_rw[r], tbl_size[r], tbl_addr[r][23:16]});
        check_value("pi_txn_in_progress", pi_txn_in_progress, 1'b1);
        pi_read(`PI_REG_STATUS_CONTROL, status);
        while (status[7])
            pi_read(`PI_REG_STATUS_CONTROL, status);
        check_value("status.terminated_normally", status[6], tbl_term[r]);
        check_value("pi_txn_in_progress", pi_txn_in_progress, 1'b0);
        n = int'(tbl_size[r]) + 1;
        if (tbl_rw[r] && tbl_term[r]) begin
            exp_data = '0;
            for (k = 0; k < n; k++)
                exp_data = {exp_data[23:0], shadow[8'(tbl_addr[r] + k)]};   // Big-endian.
            pi_read(`PI_REG_DATA_LO, lo);
            pi_read(`PI_REG_DATA_HI, hi);
            check_value("data_read", {hi, lo}, exp_data);
        end else if (!tbl_rw[r] && tbl_term[r]) begin
            for (k = 0; k < n; k++)
                shadow[8'(tbl_addr[r] + k)] = tbl_data[r][8 * (n - 1 - k) +: 8];
        end
    endtask

    // Bus strobes and enables seen around each cycle.
    always @(negedge mc_as_n_out) begin
        #1;
        check_value("mc_fc", mc_fc, FC_SUPER_DATA);
        check_value("mc_bus_oe", mc_bus_oe, 1'b1);
        check_value("addr_oe_n", addr_oe_n, 1'b0);
        check_value("mc_ds_n_out", mc_ds_n_out, !mc_rw);   // DS with AS on reads.
    end

    always @(posedge addr_le) begin
        #1;
        check_value("da_oe", da_oe, 32'hffff_ffff);
    end

    always @(posedge mc_as_n_out) begin
        #1;
        if (rst_n)
            check_value("data_oe_n", data_oe_n, 1'b0);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the DUT did not finish the tests in time");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : main
        pi_word_t status;
        int i;
        pi_a = '0;
        pi_d_in = '0;
        pi_wr_n = 1'b1;
        pi_rd_n = 1'b1;
        mc_ipl_n = 3'b111;
        n_rows = 0;
        n_checks = 0;
        n_errors = 0;
        seed = 32'h0a35_8955;
        for (i = 0; i < 256; i++) begin
            bus_model.mem[i] = 8'(i * 37 + 27);
            shadow[i] = 8'(i * 37 + 27);
        end
        build_table();
        @(posedge rst_n);
        repeat (2) @(posedge clk);
        #1;

        check_value("reset_oe", reset_oe, 1'b1);
        check_value("halt_oe", halt_oe, 1'b1);
        check_value("br_oe", br_oe, 1'b0);
        pi_read(`PI_REG_STATUS_CONTROL, status);
        check_value("status.is_bm", status[0], 1'b0);

        pi_write(`PI_REG_STATUS_CONTROL, 16'h8000 | (16'd1 << `CTRL_BIT_REQUEST_BM)
                 | (16'd1 << `CTRL_BIT_DRIVE_INT6));
        check_value("br_oe", br_oe, 1'b1);
        check_value("int6_oe", int6_oe, 1'b1);
        check_value("int2_oe", int2_oe, 1'b0);
        pi_write(`PI_REG_STATUS_CONTROL, 16'd1 << `CTRL_BIT_DRIVE_HALT);
        check_value("halt_oe", halt_oe, 1'b0);
        check_value("reset_oe", reset_oe, 1'b1);
        // RESET on the bus would end every cycle abnormally.
        pi_write(`PI_REG_STATUS_CONTROL, 16'd1 << `CTRL_BIT_DRIVE_RESET);
        check_value("reset_oe", reset_oe, 1'b0);
        pi_read(`PI_REG_STATUS_CONTROL, status);
        while (!status[0])
            pi_read(`PI_REG_STATUS_CONTROL, status);
        repeat (4) @(posedge mc_clk);
        pi_read(`PI_REG_STATUS_CONTROL, status);
        check_value("status.reset", status[1], 1'b0);
        check_value("status.halt", status[2], 1'b0);

        for (i = 0; i < n_rows; i++)
            run_row(i);

        @(posedge clk);
        #1;
        mc_ipl_n = 3'b010;
        repeat (6) @(posedge mc_clk);   // Sync delay plus two agreeing samples.
        pi_read(`PI_REG_STATUS_CONTROL, status);
        check_value("status.ipl", status[5:3], 3'b101);

        $display("checks %0d errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// File: src.f
+incdir+.
pistorm_pkg.sv
mc_clk_edges.sv
pi_regs.sv
mc_input_sync.sv
byte_lane_router.sv
bus_cycle_fsm.sv
pistorm.sv
tb_clock_gen.sv
tb_mc_bus_model.sv
tb_pistorm.sv
